/* eth_mac_1g.f */
+incdir+.
eth_mac_pkg.sv
mac_stat_if.sv
gmii_tx.sv
gmii_rx.sv
eth_mac_stats.sv
eth_mac_1g.sv
eth_mac_asserts.sv
tb_eth_mac_1g.sv

/* eth_mac_1g.sv */
// Single clock, no MAC control or timestamps; receive stream has no back-pressure
`timescale 1ns/1ps
`include "eth_mac_macros.svh"

module eth_mac_1g (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [`ETH_DATA_W-1:0]  s_axis_tx_tdata,
    input  logic                    s_axis_tx_tvalid,
    output logic                    s_axis_tx_tready,
    input  logic                    s_axis_tx_tlast,
    input  logic                    s_axis_tx_tuser,

    output logic [`ETH_DATA_W-1:0]  m_axis_rx_tdata,
    output logic                    m_axis_rx_tvalid,
    output logic                    m_axis_rx_tlast,
    output logic                    m_axis_rx_tuser,

    input  logic [`ETH_DATA_W-1:0]  gmii_rxd,
    input  logic                    gmii_rx_dv,
    input  logic                    gmii_rx_er,
    output logic [`ETH_DATA_W-1:0]  gmii_txd,
    output logic                    gmii_tx_en,
    output logic                    gmii_tx_er,

    input  logic [7:0]              cfg_tx_ifg,          // Raised to 12 if lower
    input  logic [15:0]             cfg_rx_max_pkt_len,

    input  logic [`STAT_ADDR_W-1:0] stat_addr,
    output logic [`STAT_CNT_W-1:0]  stat_data
);

    mac_stat_if tx_stat ();
    mac_stat_if rx_stat ();

    gmii_tx #(
        .PADDING_EN    (1'b1),
        .MIN_FRAME_LEN (`ETH_MIN_FRAME_LEN)
    ) tx_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_axis_tx_tdata  (s_axis_tx_tdata),
        .s_axis_tx_tvalid (s_axis_tx_tvalid),
        .s_axis_tx_tready (s_axis_tx_tready),
        .s_axis_tx_tlast  (s_axis_tx_tlast),
        .s_axis_tx_tuser  (s_axis_tx_tuser),
        .gmii_txd         (gmii_txd),
        .gmii_tx_en       (gmii_tx_en),
        .gmii_tx_er       (gmii_tx_er),
        .cfg_tx_ifg       (cfg_tx_ifg),
        .tx_stat          (tx_stat)
    );

    gmii_rx rx_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .gmii_rxd           (gmii_rxd),
        .gmii_rx_dv         (gmii_rx_dv),
        .gmii_rx_er         (gmii_rx_er),
        .m_axis_rx_tdata    (m_axis_rx_tdata),
        .m_axis_rx_tvalid   (m_axis_rx_tvalid),
        .m_axis_rx_tlast    (m_axis_rx_tlast),
        .m_axis_rx_tuser    (m_axis_rx_tuser),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .rx_stat            (rx_stat)
    );

    eth_mac_stats stats_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_stat   (tx_stat),
        .rx_stat   (rx_stat),
        .stat_addr (stat_addr),
        .stat_data (stat_data)
    );

endmodule

/* eth_mac_asserts.sv */
// Port-level protocol rules for eth_mac_1g; rules other than the reset rule are off during reset
`timescale 1ns/1ps

module eth_mac_asserts (
    input logic clk,
    input logic rst_n,
    input logic gmii_tx_en,
    input logic gmii_tx_er,
    input logic s_axis_tx_tready,
    input logic m_axis_rx_tvalid,
    input logic m_axis_rx_tlast,
    input logic m_axis_rx_tuser
);

    int unsigned fail_cnt = 0;   // Failed assertions so far

    tx_er_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        gmii_tx_er |-> gmii_tx_en)
        else begin
            fail_cnt++;
            $error("gmii_tx_er high while gmii_tx_en is low");
        end

    tready_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        !gmii_tx_en |-> !s_axis_tx_tready)
        else begin
            fail_cnt++;
            $error("s_axis_tx_tready high outside a frame");
        end

    rx_side_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (m_axis_rx_tlast || m_axis_rx_tuser) |-> m_axis_rx_tvalid)
        else begin
            fail_cnt++;
            $error("m_axis_rx_tlast or m_axis_rx_tuser without m_axis_rx_tvalid");
        end

    // Reset is synchronous, so outputs settle one edge after rst_n is seen low
    ctrl_low_in_reset: assert property (@(posedge clk)
        !rst_n |=> (!gmii_tx_en && !gmii_tx_er && !s_axis_tx_tready && !m_axis_rx_tvalid))
        else begin
            fail_cnt++;
            $error("Control output high during reset");
        end

endmodule

bind eth_mac_1g eth_mac_asserts prot_chk (.*);

/* eth_mac_macros.svh */
// MAC constants for an 8-bit GMII datapath; the statistic addresses must stay within 0 to 7
`ifndef ETH_MAC_MACROS_SVH
`define ETH_MAC_MACROS_SVH

`define ETH_DATA_W        8
`define ETH_PREAMBLE      8'h55
`define ETH_SFD           8'hD5
`define ETH_PREAMBLE_LEN  7
`define ETH_MIN_FRAME_LEN 64            // Including FCS
`define ETH_FCS_LEN       4
`define ETH_CRC_INIT      32'hFFFF_FFFF
`define ETH_CRC_POLY      32'hEDB8_8320 // Bit-reversed form
`define ETH_MIN_IFG       12            // Byte times

`define STAT_CNT_W        32
`define STAT_ADDR_W       3

`define STAT_TX_GOOD      3'd0
`define STAT_TX_BAD       3'd1
`define STAT_TX_BCAST     3'd2
`define STAT_TX_MCAST     3'd3
`define STAT_RX_GOOD      3'd4
`define STAT_RX_BAD       3'd5
`define STAT_RX_BCAST     3'd6
`define STAT_RX_MCAST     3'd7

`endif

/* eth_mac_pkg.sv */
// CRC-32 works LSB first on a non-inverted state; callers seed it and invert it themselves
`include "eth_mac_macros.svh"

package eth_mac_pkg;

    localparam logic [1:0] CLS_UCAST = 2'd0;
    localparam logic [1:0] CLS_MCAST = 2'd1;
    localparam logic [1:0] CLS_BCAST = 2'd2;

    // One byte of the Ethernet CRC, bit serial unrolled
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ `ETH_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // Group bit of the first destination byte marks multicast
    function automatic logic [1:0] dst_class(input logic [7:0] first_byte,
                                             input logic all_ff);
        if (all_ff) begin
            return CLS_BCAST;           // Broadcast wins over multicast
        end else if (first_byte[0]) begin
            return CLS_MCAST;
        end
        return CLS_UCAST;
    endfunction

endpackage

/* eth_mac_stats.sv */
// Counters wrap at 2^32 and are read one cycle after the address is applied
`timescale 1ns/1ps
`include "eth_mac_macros.svh"

module eth_mac_stats
    import eth_mac_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    mac_stat_if.snk                 tx_stat,
    mac_stat_if.snk                 rx_stat,
    input  logic [`STAT_ADDR_W-1:0] stat_addr,
    output logic [`STAT_CNT_W-1:0]  stat_data
);

    localparam int N_CNT = 2 ** `STAT_ADDR_W;

    logic [N_CNT-1:0]      inc;
    logic [`STAT_CNT_W-1:0] cnt [N_CNT];

    // Event to counter mapping
    assign inc[`STAT_TX_GOOD]  = tx_stat.pkt_good;
    assign inc[`STAT_TX_BAD]   = tx_stat.pkt_bad;
    assign inc[`STAT_TX_BCAST] = tx_stat.pkt_bcast;
    assign inc[`STAT_TX_MCAST] = tx_stat.pkt_mcast;
    assign inc[`STAT_RX_GOOD]  = rx_stat.pkt_good;
    assign inc[`STAT_RX_BAD]   = rx_stat.pkt_bad;
    assign inc[`STAT_RX_BCAST] = rx_stat.pkt_bcast;
    assign inc[`STAT_RX_MCAST] = rx_stat.pkt_mcast;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N_CNT; i++) begin
                cnt[i] <= '0;
            end
            stat_data <= '0;
        end else begin
            for (int i = 0; i < N_CNT; i++) begin
                if (inc[i]) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
            stat_data <= cnt[stat_addr];   // Value before this cycle's increment
        end
    end

endmodule

/* gmii_rx.sv */
// Consumer must accept every beat; frame length counts bytes after the SFD, FCS included
`timescale 1ns/1ps
`include "eth_mac_macros.svh"

module gmii_rx
    import eth_mac_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`ETH_DATA_W-1:0] gmii_rxd,
    input  logic                   gmii_rx_dv,
    input  logic                   gmii_rx_er,
    output logic [`ETH_DATA_W-1:0] m_axis_rx_tdata,
    output logic                   m_axis_rx_tvalid,
    output logic                   m_axis_rx_tlast,
    output logic                   m_axis_rx_tuser,
    input  logic [15:0]            cfg_rx_max_pkt_len,
    mac_stat_if.src                rx_stat
);

    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB_20E3; // State after a clean FCS
    localparam logic [1:0]  S_IDLE      = 2'd0;
    localparam logic [1:0]  S_PRE       = 2'd1;
    localparam logic [1:0]  S_DATA      = 2'd2;

    logic [1:0]                  state;
    logic [`ETH_DATA_W-1:0]      rxd_d;
    logic                        dv_d;
    logic                        er_d;
    logic [3:0][`ETH_DATA_W-1:0] dl;      // Holds back the FCS
    logic [2:0]                  fill;
    logic [15:0]                 len;
    logic [31:0]                 crc;
    logic [31:0]                 crc_next;
    logic                        bad;
    logic                        bad_now;
    logic                        has_data;
    logic                        frame_ok;
    logic [7:0]                  first_byte;
    logic                        all_ff;
    logic [1:0]                  cls;

    assign crc_next = crc32_byte(crc, rxd_d);
    assign bad_now  = bad || er_d || (len >= cfg_rx_max_pkt_len);   // Oversize on this byte
    assign has_data = (fill == 3'd4);
    assign frame_ok = has_data && !bad_now && (crc_next == CRC_RESIDUE);
    assign cls      = dst_class(first_byte, all_ff);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                <= S_IDLE;
            dv_d                 <= 1'b0;
            er_d                 <= 1'b0;
            m_axis_rx_tvalid     <= 1'b0;
            m_axis_rx_tlast      <= 1'b0;
            m_axis_rx_tuser      <= 1'b0;
            rx_stat.start_packet <= 1'b0;
            rx_stat.pkt_good     <= 1'b0;
            rx_stat.pkt_bad      <= 1'b0;
            rx_stat.pkt_bcast    <= 1'b0;
            rx_stat.pkt_mcast    <= 1'b0;
        end else begin
            rxd_d                <= gmii_rxd;
            dv_d                 <= gmii_rx_dv;
            er_d                 <= gmii_rx_er;
            m_axis_rx_tvalid     <= 1'b0;
            m_axis_rx_tlast      <= 1'b0;
            m_axis_rx_tuser      <= 1'b0;
            rx_stat.start_packet <= 1'b0;
            rx_stat.pkt_good     <= 1'b0;
            rx_stat.pkt_bad      <= 1'b0;
            rx_stat.pkt_bcast    <= 1'b0;
            rx_stat.pkt_mcast    <= 1'b0;
            case (state)
                S_IDLE, S_PRE: begin
                    if (dv_d && rxd_d == `ETH_SFD) begin
                        state                <= S_DATA;
                        crc                  <= `ETH_CRC_INIT;
                        fill                 <= '0;
                        len                  <= '0;
                        bad                  <= 1'b0;
                        all_ff               <= 1'b1;
                        rx_stat.start_packet <= 1'b1;
                    end else if (dv_d) begin
                        state <= S_PRE;
                    end else if (state == S_PRE) begin
                        state           <= S_IDLE;   // Carrier ended without an SFD
                        rx_stat.pkt_bad <= 1'b1;
                    end
                end
                default: begin
                    if (!dv_d) begin
                        state           <= S_IDLE;   // Nothing after the SFD
                        rx_stat.pkt_bad <= 1'b1;
                    end else begin
                        dl  <= {dl[2:0], rxd_d};
                        crc <= crc_next;
                        bad <= bad_now;
                        len <= (len == 16'hFFFF) ? len : len + 16'd1;
                        if (len == 16'd0) begin
                            first_byte <= rxd_d;
                        end
                        if (len < 16'd6 && rxd_d != 8'hFF) begin
                            all_ff <= 1'b0;
                        end
                        if (has_data) begin
                            m_axis_rx_tvalid <= 1'b1;
                            m_axis_rx_tdata  <= dl[3];
                        end else begin
                            fill <= fill + 3'd1;
                        end
                        if (!gmii_rx_dv) begin
                            // rxd_d is the last FCS byte
                            state             <= S_IDLE;
                            m_axis_rx_tlast   <= has_data;
                            m_axis_rx_tuser   <= has_data && !frame_ok;
                            rx_stat.pkt_good  <= frame_ok;
                            rx_stat.pkt_bad   <= !frame_ok;
                            rx_stat.pkt_bcast <= frame_ok && cls == CLS_BCAST;
                            rx_stat.pkt_mcast <= frame_ok && cls == CLS_MCAST;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* gmii_tx.sv */
// Source must hold tvalid high from the first beat through tlast; there is no underflow recovery
`timescale 1ns/1ps
`include "eth_mac_macros.svh"

module gmii_tx
    import eth_mac_pkg::*;
#(
    parameter bit PADDING_EN    = 1'b1,
    parameter int MIN_FRAME_LEN = `ETH_MIN_FRAME_LEN
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`ETH_DATA_W-1:0] s_axis_tx_tdata,
    input  logic                   s_axis_tx_tvalid,
    output logic                   s_axis_tx_tready,
    input  logic                   s_axis_tx_tlast,
    input  logic                   s_axis_tx_tuser,
    output logic [`ETH_DATA_W-1:0] gmii_txd,
    output logic                   gmii_tx_en,
    output logic                   gmii_tx_er,
    input  logic [7:0]             cfg_tx_ifg,
    mac_stat_if.src                tx_stat
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_PREAMBLE = 3'd1;
    localparam logic [2:0] S_PAYLOAD  = 3'd2;
    localparam logic [2:0] S_PAD      = 3'd3;
    localparam logic [2:0] S_FCS      = 3'd4;
    localparam logic [2:0] S_GAP      = 3'd5;
    localparam int         PAD_LEN    = MIN_FRAME_LEN - `ETH_FCS_LEN;

    logic [2:0]  state;
    logic [15:0] cnt;          // Shared byte counter
    logic [31:0] crc;
    logic [31:0] fcs;
    logic        err;          // User error latched at tlast
    logic [7:0]  first_byte;
    logic        all_ff;
    logic [1:0]  cls;
    logic [7:0]  ifg_eff;
    logic        beat;

    assign s_axis_tx_tready = (state == S_PAYLOAD);
    assign beat             = s_axis_tx_tvalid && s_axis_tx_tready;
    assign fcs              = err ? crc : ~crc;   // Inverted FCS poisons the frame
    assign cls              = dst_class(first_byte, all_ff);
    assign ifg_eff          = (cfg_tx_ifg < 8'(`ETH_MIN_IFG)) ? 8'(`ETH_MIN_IFG) : cfg_tx_ifg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state                <= S_IDLE;
            cnt                  <= '0;
            gmii_tx_en           <= 1'b0;
            gmii_tx_er           <= 1'b0;
            tx_stat.start_packet <= 1'b0;
            tx_stat.pkt_good     <= 1'b0;
            tx_stat.pkt_bad      <= 1'b0;
            tx_stat.pkt_bcast    <= 1'b0;
            tx_stat.pkt_mcast    <= 1'b0;
        end else begin
            tx_stat.start_packet <= 1'b0;
            tx_stat.pkt_good     <= 1'b0;
            tx_stat.pkt_bad      <= 1'b0;
            tx_stat.pkt_bcast    <= 1'b0;
            tx_stat.pkt_mcast    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (s_axis_tx_tvalid) begin
                        gmii_txd             <= `ETH_PREAMBLE;
                        gmii_tx_en           <= 1'b1;
                        cnt                  <= 16'd1;
                        crc                  <= `ETH_CRC_INIT;
                        all_ff               <= 1'b1;
                        tx_stat.start_packet <= 1'b1;
                        state                <= S_PREAMBLE;
                    end
                end
                S_PREAMBLE: begin
                    cnt      <= cnt + 16'd1;
                    gmii_txd <= `ETH_PREAMBLE;
                    if (cnt == 16'(`ETH_PREAMBLE_LEN)) begin
                        gmii_txd <= `ETH_SFD;
                        cnt      <= '0;
                        state    <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (beat) begin
                        gmii_txd <= s_axis_tx_tdata;
                        crc      <= crc32_byte(crc, s_axis_tx_tdata);
                        cnt      <= cnt + 16'd1;
                        if (cnt == 16'd0) begin
                            first_byte <= s_axis_tx_tdata;
                        end
                        if (cnt < 16'd6 && s_axis_tx_tdata != 8'hFF) begin
                            all_ff <= 1'b0;
                        end
                        if (s_axis_tx_tlast) begin
                            err <= s_axis_tx_tuser;
                            if (PADDING_EN && (cnt + 16'd1) < PAD_LEN) begin
                                state <= S_PAD;
                            end else begin
                                cnt   <= '0;
                                state <= S_FCS;
                            end
                        end
                    end
                end
                S_PAD: begin
                    gmii_txd <= '0;
                    crc      <= crc32_byte(crc, 8'h00);
                    cnt      <= cnt + 16'd1;
                    if (cnt < 16'd6) begin
                        all_ff <= 1'b0;                 // Zero pad inside the address
                    end
                    if ((cnt + 16'd1) == PAD_LEN) begin
                        cnt   <= '0;
                        state <= S_FCS;
                    end
                end
                S_FCS: begin
                    gmii_txd   <= fcs[8*cnt[1:0] +: 8]; // LSB first
                    gmii_tx_er <= err;
                    cnt        <= cnt + 16'd1;
                    if (cnt == 16'd3) begin
                        tx_stat.pkt_good  <= !err;
                        tx_stat.pkt_bad   <= err;
                        tx_stat.pkt_bcast <= !err && cls == CLS_BCAST;
                        tx_stat.pkt_mcast <= !err && cls == CLS_MCAST;
                        cnt               <= '0;
                        state             <= S_GAP;
                    end
                end
                default: begin
                    // Idle state adds the last gap cycle
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    cnt        <= cnt + 16'd1;
                    if ((cnt + 16'd1) >= {8'd0, ifg_eff}) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* mac_stat_if.sv */
// All signals are single-cycle pulses in the MAC clock domain
`timescale 1ns/1ps

interface mac_stat_if;
    logic start_packet;   // Frame start seen
    logic pkt_good;
    logic pkt_bad;
    logic pkt_bcast;      // Good frames only
    logic pkt_mcast;      // Good frames only, never with pkt_bcast

    modport src (output start_packet, pkt_good, pkt_bad, pkt_bcast, pkt_mcast);
    modport snk (input start_packet, pkt_good, pkt_bad, pkt_bcast, pkt_mcast);
endinterface

/* tb_eth_mac_1g.sv */
// Stimulus is fixed by seed 32'hdfdc; any wait longer than WAIT_LIMIT cycles ends the run as failed
`timescale 1ns/1ps
`include "eth_mac_macros.svh"

module tb_eth_mac_1g;

    localparam int WAIT_LIMIT = 3000;   // Cycles
    localparam int RX_MAX_LEN = 1518;

    logic                    clk;
    logic                    rst_n;
    logic [`ETH_DATA_W-1:0]  s_axis_tx_tdata;
    logic                    s_axis_tx_tvalid;
    logic                    s_axis_tx_tready;
    logic                    s_axis_tx_tlast;
    logic                    s_axis_tx_tuser;
    logic [`ETH_DATA_W-1:0]  m_axis_rx_tdata;
    logic                    m_axis_rx_tvalid;
    logic                    m_axis_rx_tlast;
    logic                    m_axis_rx_tuser;
    logic [`ETH_DATA_W-1:0]  gmii_rxd;
    logic                    gmii_rx_dv;
    logic                    gmii_rx_er;
    logic [`ETH_DATA_W-1:0]  gmii_txd;
    logic                    gmii_tx_en;
    logic                    gmii_tx_er;
    logic [7:0]              cfg_tx_ifg;
    logic [15:0]             cfg_rx_max_pkt_len;
    logic [`STAT_ADDR_W-1:0] stat_addr;
    logic [`STAT_CNT_W-1:0]  stat_data;

    int errors;
    int mark;
    int last_ifg;        // Gap owed after the previous transmit frame
    bit tx_seen;
    int model_cnt [8];

    eth_mac_1g uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    // Reflected CRC-32, one bit per step
    function automatic logic [31:0] crc_step(input logic [31:0] state, input logic [7:0] data);
        logic [31:0] c;
        logic        fb;
        c = state;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ data[i];
            c  = {1'b0, c[31:1]} ^ (fb ? `ETH_CRC_POLY : 32'd0);
        end
        return c;
    endfunction

    function automatic logic [31:0] fcs_of(input logic [7:0] data [$]);
        logic [31:0] c;
        c = `ETH_CRC_INIT;
        foreach (data[i]) begin
            c = crc_step(c, data[i]);
        end
        return ~c;
    endfunction

    // 0 unicast, 1 multicast, 2 broadcast
    function automatic int dest_kind(input logic [7:0] data [$]);
        bit all_ff;
        all_ff = 1'b1;
        for (int i = 0; i < 6; i++) begin
            if (data[i] != 8'hFF) begin
                all_ff = 1'b0;
            end
        end
        if (all_ff) begin
            return 2;
        end
        return data[0][0] ? 1 : 0;
    endfunction

    task automatic make_payload(input int len, output logic [7:0] data [$]);
        int kind;
        kind = $urandom_range(0, 2);
        data = {};
        for (int i = 0; i < len; i++) begin
            data.push_back(8'($urandom));
        end
        if (kind == 2) begin
            for (int i = 0; i < 6 && i < len; i++) begin
                data[i] = 8'hFF;
            end
        end else begin
            data[0][0] = (kind == 1);                  // Group bit
        end
    endtask

    task automatic count_frame(input bit is_rx, input bit good, input int kind);
        if (!good) begin
            model_cnt[is_rx ? `STAT_RX_BAD : `STAT_TX_BAD]++;
        end else begin
            model_cnt[is_rx ? `STAT_RX_GOOD : `STAT_TX_GOOD]++;
            if (kind == 2) begin
                model_cnt[is_rx ? `STAT_RX_BCAST : `STAT_TX_BCAST]++;
            end else if (kind == 1) begin
                model_cnt[is_rx ? `STAT_RX_MCAST : `STAT_TX_MCAST]++;
            end
        end
    endtask

    task automatic compare_frame(input string name, input logic [7:0] exp [$],
                                 input logic [7:0] got [$]);
        expect_eq({name, " length"}, exp.size(), got.size());
        for (int i = 0; i < exp.size() && i < got.size(); i++) begin
            if (got[i] !== exp[i]) begin
                errors++;
                $display("MISMATCH at %0t ns: %s[%0d] expected %h got %h",
                         $time, name, i, exp[i], got[i]);
                break;
            end
        end
    endtask

    task automatic drive_tx(input logic [7:0] data [$], input bit err, input int ifg_next);
        int idx;
        int t;
        bit take;
        idx = 0;
        t   = 0;
        @(negedge clk);
        while (idx < data.size()) begin
            s_axis_tx_tvalid = 1'b1;
            s_axis_tx_tdata  = data[idx];
            s_axis_tx_tlast  = (idx == data.size() - 1);
            s_axis_tx_tuser  = err && (idx == data.size() - 1);
            take             = s_axis_tx_tready;   // Beat lands on the next rising edge
            @(negedge clk);
            if (take) begin
                idx++;
            end
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("s_axis_tx_tready");
            end
        end
        s_axis_tx_tvalid = 1'b0;
        s_axis_tx_tlast  = 1'b0;
        s_axis_tx_tuser  = 1'b0;
        cfg_tx_ifg       = 8'(ifg_next);           // Applies to the gap after this frame
    endtask

    task automatic capture_tx(output logic [7:0] txd [$], output logic er [$], output int gap);
        int t;
        txd = {};
        er  = {};
        gap = 0;
        t   = 0;
        @(negedge clk);
        while (!gmii_tx_en) begin
            gap++;
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("gmii_tx_en to rise");
            end
            @(negedge clk);
        end
        while (gmii_tx_en) begin
            txd.push_back(gmii_txd);
            er.push_back(gmii_tx_er);
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("gmii_tx_en to fall");
            end
            @(negedge clk);
        end
    endtask

    task automatic send_tx_frame(input int len, input bit err, input int ifg_next);
        logic [7:0]  data [$];
        logic [7:0]  body [$];
        logic [7:0]  exp [$];
        logic [7:0]  got [$];
        logic        er [$];
        logic [31:0] fcs;
        logic        exp_er;
        int          gap;
        make_payload(len, data);
        body = data;
        while (body.size() < `ETH_MIN_FRAME_LEN - `ETH_FCS_LEN) begin
            body.push_back(8'h00);
        end
        fcs = err ? ~fcs_of(body) : fcs_of(body);
        exp = {};
        repeat (`ETH_PREAMBLE_LEN) exp.push_back(`ETH_PREAMBLE);
        exp.push_back(`ETH_SFD);
        exp = {exp, body};
        for (int i = 0; i < `ETH_FCS_LEN; i++) begin
            exp.push_back(fcs[8*i +: 8]);              // LSB first
        end
        fork
            drive_tx(data, err, ifg_next);
            capture_tx(got, er, gap);
        join
        if (tx_seen && gap + 1 < last_ifg) begin       // First low cycle seen by the last capture
            errors++;
            $display("MISMATCH at %0t ns: gmii_tx_en low gap expected >= %0d got %0d",
                     $time, last_ifg, gap + 1);
        end
        tx_seen  = 1'b1;
        last_ifg = ifg_next;
        compare_frame("gmii_txd", exp, got);
        foreach (er[i]) begin
            exp_er = err && (i >= er.size() - `ETH_FCS_LEN);
            if (er[i] !== exp_er) begin
                errors++;
                $display("MISMATCH at %0t ns: gmii_tx_er[%0d] expected %b got %b",
                         $time, i, exp_er, er[i]);
                break;
            end
        end
        count_frame(1'b0, !err, dest_kind(body));
    endtask

    task automatic drive_rx(input logic [7:0] bytes [$], input int er_at);
        foreach (bytes[i]) begin
            @(negedge clk);
            gmii_rxd   = bytes[i];
            gmii_rx_dv = 1'b1;
            gmii_rx_er = (i == er_at);
        end
        @(negedge clk);
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        repeat ($urandom_range(2, 10)) @(negedge clk);   // Random idle gap
    endtask

    task automatic capture_rx(output logic [7:0] data [$], output logic user);
        int t;
        bit done;
        data = {};
        user = 1'b0;
        done = 1'b0;
        t    = 0;
        while (!done) begin
            @(negedge clk);
            if (m_axis_rx_tvalid) begin
                data.push_back(m_axis_rx_tdata);
                if (m_axis_rx_tlast) begin
                    user = m_axis_rx_tuser;
                    done = 1'b1;
                end
            end
            t++;
            if (t > WAIT_LIMIT) begin
                abort_on_timeout("m_axis_rx_tlast");
            end
        end
    endtask

    // Fault 0 none, 1 corrupt FCS, 2 rx_er mid-frame, 3 longer than max length
    task automatic recv_frame(input int len, input int fault);
        logic [7:0]  data [$];
        logic [7:0]  bytes [$];
        logic [7:0]  got [$];
        logic        user;
        logic [31:0] fcs;
        make_payload(len, data);
        fcs   = fcs_of(data);
        bytes = {};
        repeat (`ETH_PREAMBLE_LEN) bytes.push_back(`ETH_PREAMBLE);
        bytes.push_back(`ETH_SFD);
        bytes = {bytes, data};
        for (int i = 0; i < `ETH_FCS_LEN; i++) begin
            bytes.push_back(fcs[8*i +: 8]);
        end
        if (fault == 1) begin
            bytes[bytes.size() - 2] ^= 8'h10;
        end
        if (fault == 3) begin
            cfg_rx_max_pkt_len = 16'(len);             // Frame with FCS is 4 bytes over
        end
        fork
            drive_rx(bytes, (fault == 2) ? 8 + len / 2 : -1);
            capture_rx(got, user);
        join
        cfg_rx_max_pkt_len = 16'(RX_MAX_LEN);
        compare_frame("m_axis_rx_tdata", data, got);
        expect_eq("m_axis_rx_tuser", (fault != 0), user);
        count_frame(1'b1, fault == 0, dest_kind(data));
    endtask

    initial begin
        int ifg;
        rst_n              = 1'b0;
        s_axis_tx_tdata    = '0;
        s_axis_tx_tvalid   = 1'b0;
        s_axis_tx_tlast    = 1'b0;
        s_axis_tx_tuser    = 1'b0;
        gmii_rxd           = '0;
        gmii_rx_dv         = 1'b0;
        gmii_rx_er         = 1'b0;
        cfg_tx_ifg         = 8'd12;
        cfg_rx_max_pkt_len = 16'(RX_MAX_LEN);
        stat_addr          = '0;
        errors             = 0;
        last_ifg           = 12;
        tx_seen            = 1'b0;
        foreach (model_cnt[i]) begin
            model_cnt[i] = 0;
        end
        void'($urandom(32'hdfdc));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        for (int n = 0; n < 20; n++) begin
            send_tx_frame($urandom_range(1, 100), 1'b0, 12);
        end
        $display("Test 1 transmit framing: 20 frames, %0d errors", errors - mark);

        mark = errors;
        for (int n = 0; n < 10; n++) begin
            ifg = $urandom_range(12, 20);
            send_tx_frame($urandom_range(1, 100), (n % 3 == 0), ifg);
        end
        $display("Test 2 transmit error and gap: 10 frames, %0d errors", errors - mark);

        mark = errors;
        for (int n = 0; n < 10; n++) begin
            recv_frame($urandom_range(60, 100), 0);
        end
        $display("Test 3 receive good frames: 10 frames, %0d errors", errors - mark);

        mark = errors;
        for (int f = 1; f <= 3; f++) begin
            recv_frame($urandom_range(60, 100), f);
        end
        $display("Test 4 receive bad frames: 3 frames, %0d errors", errors - mark);

        mark = errors;
        repeat (2) @(negedge clk);                     // Last pulse reaches its counter
        for (int a = 0; a < 8; a++) begin
            stat_addr = 3'(a);
            @(negedge clk);
            expect_eq($sformatf("stat_data[%0d]", a), model_cnt[a], stat_data);
        end
        $display("Test 5 statistics: 8 counters, %0d errors", errors - mark);

        $display("Summary: %0d check errors, %0d assertion failures",
                 errors, uut.prot_chk.fail_cnt);
        if (errors == 0 && uut.prot_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
